// ==== source/exu_isa_pkg.sv ====
`default_nettype none

package exu_isa_pkg;

  // widest datapath any instance may select
  localparam int XLEN_MAX = 64;

  // major opcodes
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_IL     = 7'b0000011;
  localparam logic [6:0] OP_S      = 7'b0100011;
  localparam logic [6:0] OP_B      = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // alu operations
  localparam logic [3:0] ADD  = 4'd0;
  localparam logic [3:0] SUB  = 4'd1;
  localparam logic [3:0] XOR  = 4'd2;
  localparam logic [3:0] OR   = 4'd3;
  localparam logic [3:0] AND  = 4'd4;
  localparam logic [3:0] SLL  = 4'd5;
  localparam logic [3:0] SRL  = 4'd6;
  localparam logic [3:0] SRA  = 4'd7;
  localparam logic [3:0] SLT  = 4'd8;
  localparam logic [3:0] SLTU = 4'd9;
  localparam logic [3:0] SLE  = 4'd10;
  localparam logic [3:0] SLEU = 4'd11;

  // funct3 of the system opcode
  localparam logic [2:0] SYS_PRIV = 3'b000;
  localparam logic [2:0] CSRRW    = 3'b001;
  localparam logic [2:0] CSRRS    = 3'b010;
  localparam logic [2:0] CSRRC    = 3'b011;
  localparam logic [2:0] CSRRWI   = 3'b101;
  localparam logic [2:0] CSRRSI   = 3'b110;
  localparam logic [2:0] CSRRCI   = 3'b111;

  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  // immediate word, also read as a system selector
  typedef union packed {
    logic [XLEN_MAX-1:0] value;
    struct packed {
      logic [XLEN_MAX-17:0] rsvd;
      logic [11:0]          sel;
      logic                 spare;
      logic [2:0]           func;
    } sys;
  } imm_u;

endpackage

`default_nettype wire

// ==== source/exu_csr_pkg.sv ====
`default_nettype none

package exu_csr_pkg;

  // machine csr addresses
  localparam logic [11:0] MSTATUS = 12'h300;
  localparam logic [11:0] MTVEC   = 12'h305;
  localparam logic [11:0] MEPC    = 12'h341;
  localparam logic [11:0] MCAUSE  = 12'h342;

  // environment call from m-mode
  localparam int unsigned CAUSE_ECALL_M = 11;

  // mstatus fields
  localparam int MIE  = 3;
  localparam int MPIE = 7;
  // low bit of the two-bit mpp field
  localparam int MPP  = 11;

endpackage

`default_nettype wire

// ==== source/exu_op_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface exu_op_if #(
  parameter int BIT_W = 32
);

  logic [6:0]          opcode;
  logic [3:0]          alu_op;
  exu_isa_pkg::imm_u   imm;
  logic [BIT_W-1:0]    src1;
  logic [BIT_W-1:0]    src2;
  logic [BIT_W-1:0]    pc;
  // op_j + imm, formed at latch time
  logic [BIT_W-1:0]    target;
  logic                occupied;

  modport stage (output opcode, alu_op, imm, src1, src2, pc, target, occupied);
  modport alu (input src1, src2, alu_op);
  modport csr (input opcode, imm, src1, pc, occupied);
  modport commit (input opcode, alu_op, imm, target);

endinterface

`default_nettype wire

// ==== source/exu_stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_stage_reg #(
  parameter int BIT_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  input  logic              next_ready_i,
  input  logic              ren_i,
  input  logic              wen_i,
  input  logic [6:0]        opcode_i,
  input  logic [3:0]        alu_op_i,
  input  exu_isa_pkg::imm_u imm_i,
  input  logic [BIT_W-1:0]  op1_i,
  input  logic [BIT_W-1:0]  op2_i,
  input  logic [BIT_W-1:0]  op_j_i,
  input  logic [BIT_W-1:0]  pc_i,
  input  logic [3:0]        rd_i,
  input  logic [BIT_W-1:0]  rwaddr_i,
  input  logic              lsu_rvalid_i,
  input  logic              lsu_wready_i,
  input  logic [BIT_W-1:0]  lsu_rdata_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic [3:0]        rd_o,
  output logic              mem_op_o,
  output logic [BIT_W-1:0]  mem_rdata_o,
  output logic              lsu_avalid_o,
  output logic [BIT_W-1:0]  lsu_addr_o,
  output logic [BIT_W-1:0]  lsu_wdata_o,
  output logic              lsu_wen_o,
  exu_op_if.stage           op
);

  logic accept;
  logic lsu_done;
  // lsu answered, result waiting for downstream
  logic mem_done;

  assign valid_o  = op.occupied & (~mem_op_o | mem_done);
  assign ready_o  = ~op.occupied | (valid_o & next_ready_i);
  assign accept   = prev_valid_i & ready_o;
  assign lsu_done = lsu_avalid_o & (lsu_wen_o ? lsu_wready_i : lsu_rvalid_i);

  // store data is the latched second operand
  assign lsu_wdata_o = op.src2;

  always_ff @(posedge clk) begin
    if (rst) begin
      op.occupied  <= 1'b0;
      mem_op_o     <= 1'b0;
      mem_done     <= 1'b0;
      lsu_avalid_o <= 1'b0;
      lsu_wen_o    <= 1'b0;
    end else begin
      if (valid_o && next_ready_i) begin
        op.occupied <= 1'b0;
        mem_done    <= 1'b0;
      end
      // a new accept overrides the drain above
      if (accept) begin
        op.occupied  <= 1'b1;
        mem_op_o     <= ren_i | wen_i;
        lsu_avalid_o <= ren_i | wen_i;
        lsu_wen_o    <= wen_i;
      end
      if (lsu_done) begin
        lsu_avalid_o <= 1'b0;
        mem_done     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op.opcode  <= opcode_i;
      op.alu_op  <= alu_op_i;
      op.imm     <= imm_i;
      op.src1    <= op1_i;
      op.src2    <= op2_i;
      op.pc      <= pc_i;
      op.target  <= op_j_i + imm_i.value[BIT_W-1:0];
      rd_o       <= rd_i;
      lsu_addr_o <= rwaddr_i;
    end
    // load data taken on the response edge
    if (lsu_done && !lsu_wen_o) begin
      mem_rdata_o <= lsu_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/exu_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_alu #(
  parameter int BIT_W = 32
) (
  exu_op_if.alu            op,
  output logic [BIT_W-1:0] alu_res_o
);

  localparam int SH_W = $clog2(BIT_W);

  logic [SH_W-1:0] shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;

  assign shamt = op.src2[SH_W-1:0];
  assign lt_s  = $signed(op.src1) < $signed(op.src2);
  assign lt_u  = op.src1 < op.src2;
  assign eq    = op.src1 == op.src2;

  always_comb begin
    case (op.alu_op)
      exu_isa_pkg::ADD:  alu_res_o = op.src1 + op.src2;
      exu_isa_pkg::SUB:  alu_res_o = op.src1 - op.src2;
      exu_isa_pkg::XOR:  alu_res_o = op.src1 ^ op.src2;
      exu_isa_pkg::OR:   alu_res_o = op.src1 | op.src2;
      exu_isa_pkg::AND:  alu_res_o = op.src1 & op.src2;
      exu_isa_pkg::SLL:  alu_res_o = op.src1 << shamt;
      exu_isa_pkg::SRL:  alu_res_o = op.src1 >> shamt;
      exu_isa_pkg::SRA:  alu_res_o = $unsigned($signed(op.src1) >>> shamt);
      // compares give 0 or 1
      exu_isa_pkg::SLT:  alu_res_o = {{(BIT_W-1){1'b0}}, lt_s};
      exu_isa_pkg::SLTU: alu_res_o = {{(BIT_W-1){1'b0}}, lt_u};
      exu_isa_pkg::SLE:  alu_res_o = {{(BIT_W-1){1'b0}}, lt_s | eq};
      exu_isa_pkg::SLEU: alu_res_o = {{(BIT_W-1){1'b0}}, lt_u | eq};
      default:           alu_res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/exu_csr_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_csr_unit #(
  parameter int BIT_W = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             commit_i,
  exu_op_if.csr            op,
  output logic [BIT_W-1:0] csr_rdata_o,
  output logic             sys_redirect_o,
  output logic [BIT_W-1:0] sys_npc_o,
  output logic             ebreak_o
);

  logic [BIT_W-1:0] mstatus;
  logic [BIT_W-1:0] mtvec;
  logic [BIT_W-1:0] mepc;
  logic [BIT_W-1:0] mcause;

  logic [2:0]       func;
  logic [11:0]      sel;
  logic             is_sys;
  logic             is_priv;
  logic             is_csr;
  logic             is_ecall;
  logic             is_mret;
  logic             is_ebreak;
  logic [BIT_W-1:0] csr_wdata;

  assign func      = op.imm.sys.func;
  assign sel       = op.imm.sys.sel;
  assign is_sys    = op.opcode == exu_isa_pkg::OP_SYSTEM;
  assign is_priv   = is_sys && func == exu_isa_pkg::SYS_PRIV;
  assign is_csr    = is_sys && func inside {exu_isa_pkg::CSRRW, exu_isa_pkg::CSRRS,
                                            exu_isa_pkg::CSRRC, exu_isa_pkg::CSRRWI,
                                            exu_isa_pkg::CSRRSI, exu_isa_pkg::CSRRCI};
  assign is_ecall  = is_priv && sel == exu_isa_pkg::F12_ECALL;
  assign is_mret   = is_priv && sel == exu_isa_pkg::F12_MRET;
  assign is_ebreak = is_priv && sel == exu_isa_pkg::F12_EBREAK;

  // old value of the addressed csr
  always_comb begin
    case (sel)
      exu_csr_pkg::MSTATUS: csr_rdata_o = mstatus;
      exu_csr_pkg::MTVEC:   csr_rdata_o = mtvec;
      exu_csr_pkg::MEPC:    csr_rdata_o = mepc;
      exu_csr_pkg::MCAUSE:  csr_rdata_o = mcause;
      default:              csr_rdata_o = '0;
    endcase
  end

  // immediate forms already carry the zero-extended uimm in src1
  always_comb begin
    case (func)
      exu_isa_pkg::CSRRS, exu_isa_pkg::CSRRSI: csr_wdata = csr_rdata_o | op.src1;
      exu_isa_pkg::CSRRC, exu_isa_pkg::CSRRCI: csr_wdata = csr_rdata_o & ~op.src1;
      default:                                 csr_wdata = op.src1;
    endcase
  end

  assign sys_redirect_o = is_ecall | is_mret;
  assign sys_npc_o      = is_ecall ? mtvec : mepc;
  assign ebreak_o       = op.occupied & is_ebreak;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (is_csr) begin
        case (sel)
          exu_csr_pkg::MSTATUS: mstatus <= csr_wdata;
          exu_csr_pkg::MTVEC:   mtvec   <= csr_wdata;
          exu_csr_pkg::MEPC:    mepc    <= csr_wdata;
          exu_csr_pkg::MCAUSE:  mcause  <= csr_wdata;
          default: ;
        endcase
      end else if (is_ecall) begin
        mepc   <= op.pc;
        mcause <= BIT_W'(exu_csr_pkg::CAUSE_ECALL_M);
      end else if (is_mret) begin
        mstatus[exu_csr_pkg::MIE]  <= mstatus[exu_csr_pkg::MPIE];
        mstatus[exu_csr_pkg::MPIE] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/exu_commit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_commit #(
  parameter int BIT_W = 32
) (
  exu_op_if.commit         op,
  input  logic [BIT_W-1:0] alu_res_i,
  input  logic [BIT_W-1:0] csr_rdata_i,
  input  logic             sys_redirect_i,
  input  logic [BIT_W-1:0] sys_npc_i,
  input  logic             mem_op_i,
  input  logic [BIT_W-1:0] mem_rdata_i,
  input  logic             valid_i,
  output logic [BIT_W-1:0] reg_wdata_o,
  output logic [BIT_W-1:0] npc_wdata_o,
  output logic             use_exu_npc_o
);

  logic is_sys;
  logic is_priv;
  logic res_zero;
  logic take;

  assign is_sys   = op.opcode == exu_isa_pkg::OP_SYSTEM;
  assign is_priv  = is_sys && op.imm.sys.func == exu_isa_pkg::SYS_PRIV;
  assign res_zero = ~|alu_res_i;

  // ecall, mret and ebreak write nothing back
  always_comb begin
    if (mem_op_i) begin
      reg_wdata_o = mem_rdata_i;
    end else if (is_priv) begin
      reg_wdata_o = '0;
    end else if (is_sys) begin
      reg_wdata_o = csr_rdata_i;
    end else begin
      reg_wdata_o = alu_res_i;
    end
  end

  assign npc_wdata_o = sys_redirect_i ? sys_npc_i : op.target;

  // branch outcome from the alu result
  always_comb begin
    case (op.opcode)
      exu_isa_pkg::OP_JAL, exu_isa_pkg::OP_JALR: take = 1'b1;
      exu_isa_pkg::OP_SYSTEM:                    take = sys_redirect_i;
      exu_isa_pkg::OP_B: begin
        case (op.alu_op)
          exu_isa_pkg::SUB:  take = res_zero;
          exu_isa_pkg::XOR,
          exu_isa_pkg::SLT,
          exu_isa_pkg::SLTU,
          exu_isa_pkg::SLE,
          exu_isa_pkg::SLEU: take = ~res_zero;
          default:           take = 1'b0;
        endcase
      end
      default: take = 1'b0;
    endcase
  end

  assign use_exu_npc_o = valid_i & take;

endmodule

`default_nettype wire

// ==== source/exu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exu_top #(
  parameter int BIT_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  input  logic              next_ready_i,
  input  logic              ren_i,
  input  logic              wen_i,
  input  logic [6:0]        opcode_i,
  input  logic [3:0]        alu_op_i,
  input  exu_isa_pkg::imm_u imm_i,
  input  logic [BIT_W-1:0]  op1_i,
  input  logic [BIT_W-1:0]  op2_i,
  input  logic [BIT_W-1:0]  op_j_i,
  input  logic [BIT_W-1:0]  pc_i,
  input  logic [3:0]        rd_i,
  input  logic [BIT_W-1:0]  rwaddr_i,
  input  logic              lsu_rvalid_i,
  input  logic              lsu_wready_i,
  input  logic [BIT_W-1:0]  lsu_rdata_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic [3:0]        rd_o,
  output logic [BIT_W-1:0]  reg_wdata_o,
  output logic [BIT_W-1:0]  npc_wdata_o,
  output logic              use_exu_npc_o,
  output logic              ebreak_o,
  output logic              lsu_avalid_o,
  output logic [BIT_W-1:0]  lsu_addr_o,
  output logic [BIT_W-1:0]  lsu_wdata_o,
  output logic              lsu_wen_o
);

  logic [BIT_W-1:0] alu_res;
  logic [BIT_W-1:0] csr_rdata;
  logic [BIT_W-1:0] sys_npc;
  logic             sys_redirect;
  logic             mem_op;
  logic [BIT_W-1:0] mem_rdata;
  // handshake edge, csr writes land here
  wire              csr_commit = valid_o & next_ready_i;

  exu_op_if #(.BIT_W(BIT_W)) u_op_if ();

  exu_stage_reg #(.BIT_W(BIT_W)) u_stage_reg (
    .clk          (clk),
    .rst          (rst),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .opcode_i     (opcode_i),
    .alu_op_i     (alu_op_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .op_j_i       (op_j_i),
    .pc_i         (pc_i),
    .rd_i         (rd_i),
    .rwaddr_i     (rwaddr_i),
    .lsu_rvalid_i (lsu_rvalid_i),
    .lsu_wready_i (lsu_wready_i),
    .lsu_rdata_i  (lsu_rdata_i),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .rd_o         (rd_o),
    .mem_op_o     (mem_op),
    .mem_rdata_o  (mem_rdata),
    .lsu_avalid_o (lsu_avalid_o),
    .lsu_addr_o   (lsu_addr_o),
    .lsu_wdata_o  (lsu_wdata_o),
    .lsu_wen_o    (lsu_wen_o),
    .op           (u_op_if.stage)
  );

  exu_alu #(.BIT_W(BIT_W)) u_alu (
    .op        (u_op_if.alu),
    .alu_res_o (alu_res)
  );

  exu_csr_unit #(.BIT_W(BIT_W)) u_csr_unit (
    .clk            (clk),
    .rst            (rst),
    .commit_i       (csr_commit),
    .op             (u_op_if.csr),
    .csr_rdata_o    (csr_rdata),
    .sys_redirect_o (sys_redirect),
    .sys_npc_o      (sys_npc),
    .ebreak_o       (ebreak_o)
  );

  exu_commit #(.BIT_W(BIT_W)) u_commit (
    .op             (u_op_if.commit),
    .alu_res_i      (alu_res),
    .csr_rdata_i    (csr_rdata),
    .sys_redirect_i (sys_redirect),
    .sys_npc_i      (sys_npc),
    .mem_op_i       (mem_op),
    .mem_rdata_i    (mem_rdata),
    .valid_i        (valid_o),
    .reg_wdata_o    (reg_wdata_o),
    .npc_wdata_o    (npc_wdata_o),
    .use_exu_npc_o  (use_exu_npc_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_exu_model.svh ====
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH
`default_nettype none

// expected alu result
function automatic logic [31:0] alu_ref(input logic [3:0] aop, input logic [31:0] a,
                                        input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (aop)
    exu_isa_pkg::ADD:  return a + b;
    exu_isa_pkg::SUB:  return a - b;
    exu_isa_pkg::XOR:  return a ^ b;
    exu_isa_pkg::OR:   return a | b;
    exu_isa_pkg::AND:  return a & b;
    exu_isa_pkg::SLL:  return a << sh;
    exu_isa_pkg::SRL:  return a >> sh;
    exu_isa_pkg::SRA:  return $unsigned($signed(a) >>> sh);
    exu_isa_pkg::SLT:  return {31'b0, $signed(a) < $signed(b)};
    exu_isa_pkg::SLTU: return {31'b0, a < b};
    exu_isa_pkg::SLE:  return {31'b0, $signed(a) <= $signed(b)};
    exu_isa_pkg::SLEU: return {31'b0, a <= b};
    default:           return 32'h0;
  endcase
endfunction

// redirect decision for jumps and branches
function automatic logic take_ref(input logic [6:0] opc, input logic [3:0] aop,
                                  input logic [31:0] res);
  if (opc == exu_isa_pkg::OP_JAL || opc == exu_isa_pkg::OP_JALR) return 1'b1;
  if (opc != exu_isa_pkg::OP_B) return 1'b0;
  if (aop == exu_isa_pkg::SUB) return res == 32'h0;
  if (aop inside {exu_isa_pkg::XOR, exu_isa_pkg::SLT, exu_isa_pkg::SLTU,
                  exu_isa_pkg::SLE, exu_isa_pkg::SLEU}) return res != 32'h0;
  return 1'b0;
endfunction

// csr value after a csr instruction
function automatic logic [31:0] csr_new_ref(input logic [2:0] func, input logic [31:0] old,
                                            input logic [31:0] src);
  if (func == exu_isa_pkg::CSRRS || func == exu_isa_pkg::CSRRSI) return old | src;
  if (func == exu_isa_pkg::CSRRC || func == exu_isa_pkg::CSRRCI) return old & ~src;
  return src;
endfunction

// mstatus after mret
function automatic logic [31:0] mret_status_ref(input logic [31:0] old);
  logic [31:0] n;
  n = old;
  n[exu_csr_pkg::MIE]  = old[exu_csr_pkg::MPIE];
  n[exu_csr_pkg::MPIE] = 1'b1;
  return n;
endfunction

`default_nettype wire
`endif

// ==== verif/tb_exu_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tb_exu_model.svh"
`default_nettype none

module tb_exu_top;

  typedef struct packed {
    logic [31:0] wdata;
    logic        chk_wdata;
    logic [31:0] npc;
    logic        redir;
    logic        ebrk;
    logic [3:0]  rd;
    logic        is_mem;
    logic        is_store;
    logic [31:0] addr;
    logic [31:0] sdata;
  } exp_t;

  logic clk, rst, prev_valid_i, next_ready_i, ren_i, wen_i;
  logic [6:0] opcode_i;
  logic [3:0] alu_op_i, rd_i, rd_o;
  exu_isa_pkg::imm_u imm_i;
  logic [31:0] op1_i, op2_i, op_j_i, pc_i, rwaddr_i, lsu_rdata_i;
  logic lsu_rvalid_i, lsu_wready_i, valid_o, ready_o, use_exu_npc_o, ebreak_o;
  logic lsu_avalid_o, lsu_wen_o;
  logic [31:0] reg_wdata_o, npc_wdata_o, lsu_addr_o, lsu_wdata_o;

  integer seed = 32'h1189db10;
  exp_t exp_q[$];
  logic [31:0] mem [16];
  logic [31:0] mstatus_m = '0, mtvec_m = '0, mepc_m = '0, mcause_m = '0;

  exu_top #(.BIT_W(32)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h got %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] csr_model_read(input logic [11:0] sel);
    case (sel)
      exu_csr_pkg::MSTATUS: return mstatus_m;
      exu_csr_pkg::MTVEC:   return mtvec_m;
      exu_csr_pkg::MEPC:    return mepc_m;
      exu_csr_pkg::MCAUSE:  return mcause_m;
      default:              return 32'h0;
    endcase
  endfunction

  task automatic csr_model_write(input logic [11:0] sel, input logic [31:0] v);
    case (sel)
      exu_csr_pkg::MSTATUS: mstatus_m = v;
      exu_csr_pkg::MTVEC:   mtvec_m = v;
      exu_csr_pkg::MEPC:    mepc_m = v;
      exu_csr_pkg::MCAUSE:  mcause_m = v;
      default: ;
    endcase
  endtask

  // drive one instruction, wait for the transfer, queue its expected result
  task automatic issue(input logic [6:0] opc, input logic [3:0] aop,
                       input exu_isa_pkg::imm_u imm, input logic [31:0] a,
                       input logic [31:0] b, input logic rd_en, input logic wr_en,
                       input logic [31:0] addr);
    exp_t e;
    int t;
    logic [31:0] old;
    opcode_i = opc;
    alu_op_i = aop;
    imm_i = imm;
    op1_i = a;
    op2_i = b;
    ren_i = rd_en;
    wen_i = wr_en;
    rwaddr_i = addr;
    op_j_i = $random(seed);
    pc_i = {$random(seed)} & 32'hffff_fffc;
    rd_i = 4'($unsigned($random(seed)));
    prev_valid_i = 1'b1;
    t = 0;
    #40;
    while (!ready_o) begin
      t++;
      if (t > 60) fail_now("instruction was not accepted within 60 cycles");
      @(negedge clk);
      #40;
    end
    e = '0;
    e.rd = rd_i;
    e.npc = op_j_i + imm.value[31:0];
    e.is_mem = rd_en | wr_en;
    e.is_store = wr_en;
    e.addr = addr;
    e.sdata = b;
    e.chk_wdata = !wr_en;
    if (rd_en) begin
      e.wdata = mem[addr[5:2]];
    end else if (opc == exu_isa_pkg::OP_SYSTEM && imm.sys.func == exu_isa_pkg::SYS_PRIV) begin
      if (imm.sys.sel == exu_isa_pkg::F12_ECALL) begin
        e.redir = 1'b1;
        e.npc = mtvec_m;
        mepc_m = pc_i;
        mcause_m = exu_csr_pkg::CAUSE_ECALL_M;
      end else if (imm.sys.sel == exu_isa_pkg::F12_MRET) begin
        e.redir = 1'b1;
        e.npc = mepc_m;
        mstatus_m = mret_status_ref(mstatus_m);
      end else begin
        e.ebrk = 1'b1;
      end
    end else if (opc == exu_isa_pkg::OP_SYSTEM) begin
      old = csr_model_read(imm.sys.sel);
      e.wdata = old;
      csr_model_write(imm.sys.sel, csr_new_ref(imm.sys.func, old, a));
    end else if (!wr_en) begin
      e.wdata = alu_ref(aop, a, b);
      e.redir = take_ref(opc, aop, e.wdata);
    end
    @(negedge clk);
    prev_valid_i = 1'b0;
    // queued once the transfer edge has passed
    exp_q.push_back(e);
  endtask

  function automatic exu_isa_pkg::imm_u sys_imm(input logic [2:0] func, input logic [11:0] sel);
    exu_isa_pkg::imm_u imm;
    imm.value = '0;
    imm.sys.func = func;
    imm.sys.sel = sel;
    return imm;
  endfunction

  task automatic send_rand(input logic [6:0] opc, input logic [3:0] aop);
    exu_isa_pkg::imm_u imm;
    logic [31:0] a;
    logic [31:0] b;
    imm.value = {32'h0, $random(seed)};
    a = $random(seed);
    // equal operands now and then, so SUB branches get taken
    b = ($unsigned($random(seed)) % 3 == 0) ? a : $random(seed);
    issue(opc, aop, imm, a, b, 1'b0, 1'b0, 32'h0);
  endtask

  task automatic send_mem(input logic store);
    exu_isa_pkg::imm_u imm;
    imm.value = {32'h0, $random(seed)};
    issue(store ? exu_isa_pkg::OP_S : exu_isa_pkg::OP_IL, exu_isa_pkg::ADD, imm,
          $random(seed), $random(seed), !store, store,
          32'h1000_0000 | ({$random(seed)} & 32'h3c));
  endtask

  task automatic send_sys(input logic [2:0] func, input logic [11:0] sel, input logic [31:0] src);
    issue(exu_isa_pkg::OP_SYSTEM, exu_isa_pkg::ADD, sys_imm(func, sel), src, $random(seed),
          1'b0, 1'b0, 32'h0);
  endtask

  // downstream back-pressure and the lsu responder
  initial begin
    int dly;
    logic busy;
    busy = 1'b0;
    dly = 0;
    forever begin
      @(negedge clk);
      lsu_rvalid_i = 1'b0;
      lsu_wready_i = 1'b0;
      next_ready_i = ($unsigned($random(seed)) % 4) != 0;
      if (lsu_avalid_o && !rst) begin
        if (!busy) begin
          dly = $unsigned($random(seed)) % 6;
          busy = 1'b1;
        end
        if (dly == 0) begin
          busy = 1'b0;
          if (lsu_wen_o) begin
            mem[lsu_addr_o[5:2]] = lsu_wdata_o;
            lsu_wready_i = 1'b1;
          end else begin
            lsu_rdata_i = mem[lsu_addr_o[5:2]];
            lsu_rvalid_i = 1'b1;
          end
        end else begin
          dly--;
        end
      end
    end
  end

  // compare just before each rising edge
  initial begin
    exp_t e;
    int idle;
    idle = 0;
    repeat (11) @(negedge clk);
    #40;
    check_val("ready_o", 32'h1, 32'(ready_o));
    check_val("valid_o", 32'h0, 32'(valid_o));
    check_val("lsu_avalid_o", 32'h0, 32'(lsu_avalid_o));
    check_val("use_exu_npc_o", 32'h0, 32'(use_exu_npc_o));
    check_val("ebreak_o", 32'h0, 32'(ebreak_o));
    forever begin
      @(negedge clk);
      #40;
      if (valid_o) begin
        if (exp_q.size() == 0) fail_now("valid_o was raised with no instruction in flight");
        e = exp_q[0];
        check_val("rd_o", 32'(e.rd), 32'(rd_o));
        check_val("npc_wdata_o", e.npc, npc_wdata_o);
        check_val("use_exu_npc_o", 32'(e.redir), 32'(use_exu_npc_o));
        check_val("ebreak_o", 32'(e.ebrk), 32'(ebreak_o));
        check_val("lsu_avalid_o", 32'h0, 32'(lsu_avalid_o));
        if (e.chk_wdata) check_val("reg_wdata_o", e.wdata, reg_wdata_o);
        if (!next_ready_i) begin
          check_val("ready_o", 32'h0, 32'(ready_o));
        end else begin
          check_val("ready_o", 32'h1, 32'(ready_o));
          void'(exp_q.pop_front());
          idle = 0;
        end
      end else if (exp_q.size() != 0) begin
        e = exp_q[0];
        // only a load or store may still be waiting here
        if (!e.is_mem) fail_now("valid_o did not rise the cycle after an accepted instruction");
        check_val("lsu_avalid_o", 32'h1, 32'(lsu_avalid_o));
        check_val("lsu_addr_o", e.addr, lsu_addr_o);
        check_val("lsu_wen_o", 32'(e.is_store), 32'(lsu_wen_o));
        check_val("lsu_wdata_o", e.sdata, lsu_wdata_o);
        check_val("ready_o", 32'h0, 32'(ready_o));
      end
      if (exp_q.size() != 0) idle++;
      if (idle > 50) fail_now("stage gave no result within 50 cycles");
    end
  end

  initial begin
    int t;
    logic [3:0] br_ops [6];
    br_ops = '{exu_isa_pkg::SUB, exu_isa_pkg::XOR, exu_isa_pkg::SLT,
               exu_isa_pkg::SLTU, exu_isa_pkg::SLE, exu_isa_pkg::SLEU};
    for (int i = 0; i < 16; i++) mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0103_0507);
    rst = 1'b1;
    {prev_valid_i, next_ready_i, ren_i, wen_i, lsu_rvalid_i, lsu_wready_i} = '0;
    {opcode_i, alu_op_i, rd_i} = '0;
    imm_i = '0;
    {op1_i, op2_i, op_j_i, pc_i, rwaddr_i, lsu_rdata_i} = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int i = 0; i < 40; i++) begin
      send_rand(i % 2 ? exu_isa_pkg::OP_R : exu_isa_pkg::OP_I,
                4'($unsigned($random(seed)) % 12));
      send_rand(exu_isa_pkg::OP_B, br_ops[i % 6]);
    end
    send_rand(exu_isa_pkg::OP_JAL, exu_isa_pkg::ADD);
    send_rand(exu_isa_pkg::OP_JALR, exu_isa_pkg::ADD);
    for (int i = 0; i < 24; i++) send_mem(($unsigned($random(seed)) % 2) == 1);
    send_sys(exu_isa_pkg::CSRRW, exu_csr_pkg::MTVEC, 32'h0000_8000);
    send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MSTATUS, 32'h0000_0088);
    send_sys(exu_isa_pkg::CSRRC, exu_csr_pkg::MSTATUS, 32'h0000_0008);
    send_sys(exu_isa_pkg::CSRRWI, exu_csr_pkg::MCAUSE, 32'h0000_0017);
    send_sys(exu_isa_pkg::CSRRSI, exu_csr_pkg::MCAUSE, 32'h0000_0008);
    send_sys(exu_isa_pkg::CSRRCI, exu_csr_pkg::MCAUSE, 32'h0000_0001);
    send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MCAUSE, 32'h0);
    send_sys(exu_isa_pkg::SYS_PRIV, exu_isa_pkg::F12_ECALL, 32'h0);
    send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MEPC, 32'h0);
    send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MCAUSE, 32'h0);
    send_sys(exu_isa_pkg::CSRRW, exu_csr_pkg::MEPC, 32'h0000_4444);
    send_sys(exu_isa_pkg::SYS_PRIV, exu_isa_pkg::F12_MRET, 32'h0);
    send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MSTATUS, 32'h0);
    send_sys(exu_isa_pkg::SYS_PRIV, exu_isa_pkg::F12_EBREAK, 32'h0);
    for (int i = 0; i < 20; i++) begin
      send_rand(exu_isa_pkg::OP_B, br_ops[$unsigned($random(seed)) % 6]);
      send_mem(i % 3 == 0);
      send_sys(exu_isa_pkg::CSRRS, exu_csr_pkg::MSTATUS, 32'($unsigned($random(seed)) % 32));
      if (i % 4 == 0) repeat (2) @(negedge clk);
    end
    t = 0;
    while (exp_q.size() != 0 && t < 200) begin
      t++;
      @(negedge clk);
    end
    if (exp_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_now("results still outstanding at the end of the test");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
source/exu_isa_pkg.sv
source/exu_csr_pkg.sv
source/exu_op_if.sv
source/exu_stage_reg.sv
source/exu_alu.sv
source/exu_csr_unit.sv
source/exu_commit.sv
source/exu_top.sv
verif/tb_exu_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vlog.f --top-module tb_exu_top \
  -Mdir obj_dir -o sim_exu > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see build.log"
  exit 1
fi

./obj_dir/sim_exu > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Simulation passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1
